// ==== saber_macros.svh ====
`ifndef SABER_MACROS_SVH
`define SABER_MACROS_SVH

// song slots held in the ROM
`define NUM_BLOCKS 4

// ticks a block stays on screen before it reaches the player
`define LEAD_TICKS 4

// depth units per remaining tick
`define Z_STEP 64

// half size of a note square, in pixels
`define BLOCK_HALF 16

`define HEALTH_MAX 8

// tick at which the song is over
`define SONG_LEN 16

`define COMBO_MAX 7

`endif

// ==== saber_pkg.sv ====
package saber_pkg;

    typedef enum logic [1:0] {
        state_idle    = 2'd0,
        state_playing = 2'd1,
        state_over    = 2'd2
    } game_state_e;

    // note reading, color 0 is red and 1 is blue
    typedef struct packed {
        logic       kind;
        logic       color;
        logic [2:0] cut_dir;
        logic [2:0] pad;
    } note_view_t;

    typedef struct packed {
        logic       kind;
        logic [6:0] half_width;
    } obstacle_view_t;

    // top bit picks the reading, 1 means obstacle
    typedef union packed {
        note_view_t     note;
        obstacle_view_t obstacle;
    } block_word_u;

    // distance along one screen axis
    function automatic logic [11:0] abs_diff(input logic [11:0] a, input logic [11:0] b);
        return (a > b) ? a - b : b - a;
    endfunction

endpackage

// ==== block_loader.sv ====
`timescale 1ns/1ps
`include "saber_macros.svh"

module block_loader (
    input  logic                                    clk_in,
    input  logic                                    rst_n,
    output logic [`NUM_BLOCKS-1:0][5:0]             block_time,
    output logic [`NUM_BLOCKS-1:0][11:0]            block_x,
    output logic [`NUM_BLOCKS-1:0][11:0]            block_y,
    output saber_pkg::block_word_u [`NUM_BLOCKS-1:0] block_word
);

    function automatic saber_pkg::block_word_u note_word(input logic color,
                                                         input logic [2:0] cut_dir);
        saber_pkg::block_word_u w;
        w.note.kind    = 1'b0;
        w.note.color   = color;
        w.note.cut_dir = cut_dir;
        w.note.pad     = 3'd0;
        return w;
    endfunction

    function automatic saber_pkg::block_word_u obstacle_word(input logic [6:0] half_width);
        saber_pkg::block_word_u w;
        w.obstacle.kind       = 1'b1;
        w.obstacle.half_width = half_width;
        return w;
    endfunction

    // song table, spawn tick then centre then word
    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            block_time <= '0;
            block_x    <= '0;
            block_y    <= '0;
            block_word <= '0;
        end else begin
            for (int i = 0; i < `NUM_BLOCKS; i++) begin
                case (i)
                    0: begin
                        block_time[i] <= 6'd2;
                        block_x[i]    <= 12'd100;
                        block_y[i]    <= 12'd100;
                        block_word[i] <= note_word(1'b0, 3'd0);
                    end
                    1: begin
                        block_time[i] <= 6'd4;
                        block_x[i]    <= 12'd300;
                        block_y[i]    <= 12'd100;
                        block_word[i] <= note_word(1'b1, 3'd1);
                    end
                    2: begin
                        block_time[i] <= 6'd6;
                        block_x[i]    <= 12'd200;
                        block_y[i]    <= 12'd200;
                        block_word[i] <= obstacle_word(7'd40);
                    end
                    3: begin
                        block_time[i] <= 6'd10;
                        block_x[i]    <= 12'd400;
                        block_y[i]    <= 12'd300;
                        block_word[i] <= note_word(1'b0, 3'd2);
                    end
                    default: begin
                        block_time[i] <= 6'd0;
                        block_x[i]    <= 12'd0;
                        block_y[i]    <= 12'd0;
                        block_word[i] <= '0;
                    end
                endcase
            end
        end
    end

endmodule

// ==== block_positions.sv ====
`timescale 1ns/1ps
`include "saber_macros.svh"

module block_positions (
    input  logic                        clk_in,
    input  logic                        rst_n,
    input  logic [5:0]                  curr_time,
    input  logic [`NUM_BLOCKS-1:0][5:0] block_time,
    output logic [`NUM_BLOCKS-1:0][2:0] remaining,
    output logic [`NUM_BLOCKS-1:0][8:0] block_z,
    output logic [`NUM_BLOCKS-1:0]      block_visible
);

    logic [`NUM_BLOCKS-1:0][2:0] remaining_c;
    logic [`NUM_BLOCKS-1:0][6:0] reach_time;
    logic [`NUM_BLOCKS-1:0]      visible_c;

    // visible from spawn until the block reaches the player
    always_comb begin
        for (int i = 0; i < `NUM_BLOCKS; i++) begin
            reach_time[i]  = {1'b0, block_time[i]} + 7'(`LEAD_TICKS);
            visible_c[i]   = (curr_time >= block_time[i]) &&
                             ({1'b0, curr_time} < reach_time[i]);
            remaining_c[i] = visible_c[i] ? 3'(reach_time[i] - {1'b0, curr_time}) : 3'd0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            remaining     <= '0;
            block_z       <= '0;
            block_visible <= '0;
        end else begin
            remaining     <= remaining_c;
            block_visible <= visible_c;
            for (int i = 0; i < `NUM_BLOCKS; i++) begin
                block_z[i] <= 9'(remaining_c[i]) * 9'(`Z_STEP);
            end
        end
    end

endmodule

// ==== block_selector.sv ====
`timescale 1ns/1ps
`include "saber_macros.svh"

module block_selector (
    input  logic                                    clk_in,
    input  logic                                    rst_n,
    input  logic [10:0]                             x_in,
    input  logic [9:0]                              y_in,
    input  logic [`NUM_BLOCKS-1:0][11:0]            block_x,
    input  logic [`NUM_BLOCKS-1:0][11:0]            block_y,
    input  logic [`NUM_BLOCKS-1:0][8:0]             block_z,
    input  saber_pkg::block_word_u [`NUM_BLOCKS-1:0] block_word,
    input  logic [`NUM_BLOCKS-1:0]                  block_visible,
    input  logic [`NUM_BLOCKS-1:0]                  sliced_mask,
    output logic                                    sel_valid,
    output saber_pkg::block_word_u                  sel_word,
    output logic [8:0]                              sel_z
);

    logic [`NUM_BLOCKS-1:0][11:0] half_x;
    logic [`NUM_BLOCKS-1:0]       covers;
    logic                         found;
    saber_pkg::block_word_u       best_word;
    logic [8:0]                   best_z;

    //////////////////////////////////////////////////////////////////////
    // footprint test and nearest pick
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        found     = 1'b0;
        best_word = '0;
        best_z    = '1;
        for (int i = 0; i < `NUM_BLOCKS; i++) begin
            // obstacles are wide, notes are square
            half_x[i] = block_word[i].obstacle.kind ?
                        {5'd0, block_word[i].obstacle.half_width} : 12'(`BLOCK_HALF);
            covers[i] = block_visible[i] && !sliced_mask[i] &&
                        (saber_pkg::abs_diff({1'b0, x_in}, block_x[i]) <= half_x[i]) &&
                        (saber_pkg::abs_diff({2'b0, y_in}, block_y[i]) <= 12'(`BLOCK_HALF));
            // strict compare keeps the lower slot on a tie
            if (covers[i] && (!found || block_z[i] < best_z)) begin
                found     = 1'b1;
                best_word = block_word[i];
                best_z    = block_z[i];
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            sel_valid <= 1'b0;
        end else begin
            sel_valid <= found;
        end
    end

    always_ff @(posedge clk_in) begin
        sel_word <= best_word;
        sel_z    <= best_z;
    end

endmodule

// ==== slice_detector.sv ====
`timescale 1ns/1ps
`include "saber_macros.svh"

module slice_detector (
    input  logic                                    clk_in,
    input  logic                                    rst_n,
    input  logic                                    frame_tick,
    input  saber_pkg::game_state_e                  state,
    input  logic [`NUM_BLOCKS-1:0][2:0]             remaining,
    input  logic [`NUM_BLOCKS-1:0]                  block_visible,
    input  logic [`NUM_BLOCKS-1:0][11:0]            block_x,
    input  logic [`NUM_BLOCKS-1:0][11:0]            block_y,
    input  saber_pkg::block_word_u [`NUM_BLOCKS-1:0] block_word,
    input  logic [`NUM_BLOCKS-1:0]                  sliced_mask,
    input  logic [11:0]                             saber_x,
    input  logic [11:0]                             saber_y,
    input  logic [11:0]                             head_x,
    output logic                                    slice_pulse,
    output logic [1:0]                              slice_id,
    output logic                                    hit_pulse,
    output logic                                    miss_pulse
);

    logic                   tick_d1;
    logic                   tick_d2;
    logic                   evaluate;
    logic [`NUM_BLOCKS-1:0] note_due;
    logic [`NUM_BLOCKS-1:0] saber_in;
    logic [`NUM_BLOCKS-1:0] slice_c;
    logic [`NUM_BLOCKS-1:0] miss_c;
    logic [`NUM_BLOCKS-1:0] hit_c;
    logic [1:0]             first_slice;

    // positions for the new time are settled two cycles after the tick
    assign evaluate = tick_d2 && (state == saber_pkg::state_playing);

    always_comb begin
        for (int i = 0; i < `NUM_BLOCKS; i++) begin
            note_due[i] = block_visible[i] && (remaining[i] == 3'd1) &&
                          !block_word[i].note.kind && !sliced_mask[i];
            saber_in[i] = (saber_pkg::abs_diff(saber_x, block_x[i]) <= 12'(`BLOCK_HALF)) &&
                          (saber_pkg::abs_diff(saber_y, block_y[i]) <= 12'(`BLOCK_HALF));
            slice_c[i]  = note_due[i] && saber_in[i];
            miss_c[i]   = note_due[i] && !saber_in[i];
            hit_c[i]    = block_visible[i] && (remaining[i] == 3'd1) &&
                          block_word[i].obstacle.kind &&
                          (saber_pkg::abs_diff(head_x, block_x[i]) <=
                           {5'd0, block_word[i].obstacle.half_width});
        end
        // lowest slot wins
        first_slice = 2'd0;
        for (int i = `NUM_BLOCKS - 1; i >= 0; i--) begin
            if (slice_c[i]) begin
                first_slice = 2'(i);
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            tick_d1     <= 1'b0;
            tick_d2     <= 1'b0;
            slice_pulse <= 1'b0;
            slice_id    <= 2'd0;
            hit_pulse   <= 1'b0;
            miss_pulse  <= 1'b0;
        end else begin
            tick_d1     <= frame_tick;
            tick_d2     <= tick_d1;
            slice_pulse <= evaluate && (|slice_c);
            slice_id    <= first_slice;
            hit_pulse   <= evaluate && (|hit_c);
            miss_pulse  <= evaluate && (|miss_c);
        end
    end

endmodule

// ==== game_state.sv ====
`timescale 1ns/1ps
`include "saber_macros.svh"

module game_state (
    input  logic                   clk_in,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic                   frame_tick,
    input  logic                   slice_pulse,
    input  logic [1:0]             slice_id,
    input  logic                   hit_pulse,
    input  logic                   miss_pulse,
    output saber_pkg::game_state_e state,
    output logic [5:0]             curr_time,
    output logic [`NUM_BLOCKS-1:0] sliced_mask,
    output logic [7:0]             score,
    output logic [2:0]             combo,
    output logic [3:0]             health
);

    logic [2:0] combo_inc;
    logic [3:0] health_dec;

    always_comb begin
        combo_inc  = (combo == 3'(`COMBO_MAX)) ? combo : combo + 3'd1;
        // obstacle costs two, a miss one
        health_dec = {2'd0, hit_pulse, 1'b0} + {3'd0, miss_pulse};
    end

    //////////////////////////////////////////////////////////////////////
    // control FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state       <= saber_pkg::state_idle;
            curr_time   <= 6'd0;
            sliced_mask <= '0;
            score       <= 8'd0;
            combo       <= 3'd0;
            health      <= 4'(`HEALTH_MAX);
        end else begin
            case (state)
                saber_pkg::state_playing: begin
                    if (health == 4'd0 || curr_time >= 6'(`SONG_LEN)) begin
                        state <= saber_pkg::state_over;
                    end else if (frame_tick) begin
                        curr_time <= curr_time + 6'd1;
                    end
                    if (slice_pulse) begin
                        combo                 <= combo_inc;
                        score                 <= score + {5'd0, combo_inc};
                        sliced_mask[slice_id] <= 1'b1;
                    end
                    // any damage breaks the combo
                    if (hit_pulse || miss_pulse) begin
                        combo  <= 3'd0;
                        health <= (health > health_dec) ? health - health_dec : 4'd0;
                    end
                end
                default: begin
                    // idle and over both wait for start
                    if (start) begin
                        state       <= saber_pkg::state_playing;
                        curr_time   <= 6'd0;
                        sliced_mask <= '0;
                        score       <= 8'd0;
                        combo       <= 3'd0;
                        health      <= 4'(`HEALTH_MAX);
                    end
                end
            endcase
        end
    end

endmodule

// ==== pixel_renderer.sv ====
`timescale 1ns/1ps

module pixel_renderer (
    input  logic                   clk_in,
    input  logic                   rst_n,
    input  saber_pkg::game_state_e state,
    input  logic                   sel_valid,
    input  saber_pkg::block_word_u sel_word,
    input  logic [8:0]             sel_z,
    output logic [3:0]             r_out,
    output logic [3:0]             g_out,
    output logic [3:0]             b_out
);

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            {r_out, g_out, b_out} <= 12'h000;
        end else if (state == saber_pkg::state_over) begin
            // dim red game over screen
            {r_out, g_out, b_out} <= 12'h400;
        end else if (!sel_valid) begin
            {r_out, g_out, b_out} <= 12'h000;
        end else if (sel_word.obstacle.kind) begin
            {r_out, g_out, b_out} <= 12'h888;
        end else if (sel_word.note.color) begin
            {r_out, g_out, b_out} <= 12'h00f;
        end else begin
            {r_out, g_out, b_out} <= 12'hf00;
        end
    end

endmodule

// ==== game_logic_and_renderer.sv ====
`timescale 1ns/1ps
`include "saber_macros.svh"

module game_logic_and_renderer (
    input  logic                   clk_in,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic                   frame_tick,
    input  logic [10:0]            x_in,
    input  logic [9:0]             y_in,
    input  logic [11:0]            saber_x,
    input  logic [11:0]            saber_y,
    input  logic [11:0]            head_x,
    output logic [3:0]             r_out,
    output logic [3:0]             g_out,
    output logic [3:0]             b_out,
    output logic [7:0]             score_out,
    output logic [3:0]             health_out,
    output saber_pkg::game_state_e state_out
);

    //////////////////////////////////////////////////////////////////////
    // stage wires
    //////////////////////////////////////////////////////////////////////

    // game_state
    saber_pkg::game_state_e state;
    logic [5:0]             curr_time;
    logic [`NUM_BLOCKS-1:0] sliced_mask;

    // block_loader
    logic [`NUM_BLOCKS-1:0][5:0]             block_time;
    logic [`NUM_BLOCKS-1:0][11:0]            block_x;
    logic [`NUM_BLOCKS-1:0][11:0]            block_y;
    saber_pkg::block_word_u [`NUM_BLOCKS-1:0] block_word;

    // block_positions
    logic [`NUM_BLOCKS-1:0][2:0] remaining;
    logic [`NUM_BLOCKS-1:0][8:0] block_z;
    logic [`NUM_BLOCKS-1:0]      block_visible;

    // block_selector
    logic                   sel_valid;
    saber_pkg::block_word_u sel_word;
    logic [8:0]             sel_z;

    // events back to game_state
    logic       slice_pulse;
    logic [1:0] slice_id;
    logic       hit_pulse;
    logic       miss_pulse;

    assign state_out = state;

    //////////////////////////////////////////////////////////////////////
    // stages
    //////////////////////////////////////////////////////////////////////

    game_state game_state (
        .clk_in(clk_in),
        .rst_n(rst_n),
        .start(start),
        .frame_tick(frame_tick),
        .slice_pulse(slice_pulse),
        .slice_id(slice_id),
        .hit_pulse(hit_pulse),
        .miss_pulse(miss_pulse),
        .state(state),
        .curr_time(curr_time),
        .sliced_mask(sliced_mask),
        .score(score_out),
        .combo(),
        .health(health_out)
    );

    block_loader block_loader (
        .clk_in(clk_in),
        .rst_n(rst_n),
        .block_time(block_time),
        .block_x(block_x),
        .block_y(block_y),
        .block_word(block_word)
    );

    block_positions block_positions (
        .clk_in(clk_in),
        .rst_n(rst_n),
        .curr_time(curr_time),
        .block_time(block_time),
        .remaining(remaining),
        .block_z(block_z),
        .block_visible(block_visible)
    );

    block_selector block_selector (
        .clk_in(clk_in),
        .rst_n(rst_n),
        .x_in(x_in),
        .y_in(y_in),
        .block_x(block_x),
        .block_y(block_y),
        .block_z(block_z),
        .block_word(block_word),
        .block_visible(block_visible),
        .sliced_mask(sliced_mask),
        .sel_valid(sel_valid),
        .sel_word(sel_word),
        .sel_z(sel_z)
    );

    slice_detector slice_detector (
        .clk_in(clk_in),
        .rst_n(rst_n),
        .frame_tick(frame_tick),
        .state(state),
        .remaining(remaining),
        .block_visible(block_visible),
        .block_x(block_x),
        .block_y(block_y),
        .block_word(block_word),
        .sliced_mask(sliced_mask),
        .saber_x(saber_x),
        .saber_y(saber_y),
        .head_x(head_x),
        .slice_pulse(slice_pulse),
        .slice_id(slice_id),
        .hit_pulse(hit_pulse),
        .miss_pulse(miss_pulse)
    );

    pixel_renderer pixel_renderer (
        .clk_in(clk_in),
        .rst_n(rst_n),
        .state(state),
        .sel_valid(sel_valid),
        .sel_word(sel_word),
        .sel_z(sel_z),
        .r_out(r_out),
        .g_out(g_out),
        .b_out(b_out)
    );

endmodule

// ==== saber_tb.sv ====
`timescale 1ns/1ps
`include "saber_macros.svh"

module saber_tb;

    // enough for two full songs, pixel streams and reset
    localparam int TICK_BUDGET     = 2 * `SONG_LEN;
    localparam int WATCHDOG_CYCLES = TICK_BUDGET * 8 + 300;

    // local copy of the song table
    localparam int song_time [4] = '{2, 4, 6, 10};
    localparam int song_x    [4] = '{100, 300, 200, 400};
    localparam int song_y    [4] = '{100, 100, 200, 300};
    localparam int song_kind [4] = '{0, 0, 1, 0};
    localparam int song_color[4] = '{0, 1, 0, 0};
    localparam int song_half [4] = '{16, 16, 40, 16};

    logic                   clk_in;
    logic                   rst_n;
    logic                   start;
    logic                   frame_tick;
    logic [10:0]            x_in;
    logic [9:0]             y_in;
    logic [11:0]            saber_x;
    logic [11:0]            saber_y;
    logic [11:0]            head_x;
    logic [3:0]             r_out;
    logic [3:0]             g_out;
    logic [3:0]             b_out;
    logic [7:0]             score_out;
    logic [3:0]             health_out;
    saber_pkg::game_state_e state_out;

    // reference model of the game
    saber_pkg::game_state_e m_state;
    int                     m_time;
    logic [3:0]             m_mask;
    int                     m_score;
    int                     m_combo;
    int                     m_health;

    int          errors;
    int          checks;
    logic [31:0] rng;
    int          px_q[$];
    int          py_q[$];

    game_logic_and_renderer UUT (
        .clk_in(clk_in),
        .rst_n(rst_n),
        .start(start),
        .frame_tick(frame_tick),
        .x_in(x_in),
        .y_in(y_in),
        .saber_x(saber_x),
        .saber_y(saber_y),
        .head_x(head_x),
        .r_out(r_out),
        .g_out(g_out),
        .b_out(b_out),
        .score_out(score_out),
        .health_out(health_out),
        .state_out(state_out)
    );

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        $display("timeout: the tests did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_state(input string name, input saber_pkg::game_state_e got,
                               input saber_pkg::game_state_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_rgb(input string name, input logic [3:0] r, input logic [3:0] g,
                             input logic [3:0] b, input logic [3:0] exp_r,
                             input logic [3:0] exp_g, input logic [3:0] exp_b);
        checks++;
        if ({r, g, b} !== {exp_r, exp_g, exp_b}) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h%h%h expected 0x%h%h%h",
                     name, r, g, b, exp_r, exp_g, exp_b);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // model of the song rules
    //////////////////////////////////////////////////////////////////////

    function automatic int distance(input int a, input int b);
        return (a > b) ? a - b : b - a;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic bit slot_visible(input int i);
        return (m_time >= song_time[i]) && (m_time < song_time[i] + `LEAD_TICKS);
    endfunction

    // nearest visible unsliced block wins, lower slot on a tie
    function automatic logic [11:0] expected_rgb(input int x, input int y);
        int best;
        int best_rem;
        int rem;
        int half;
        best     = -1;
        best_rem = 0;
        if (m_state == saber_pkg::state_over) begin
            return 12'h400;
        end
        for (int i = 0; i < `NUM_BLOCKS; i++) begin
            rem  = song_time[i] + `LEAD_TICKS - m_time;
            half = song_kind[i] ? song_half[i] : `BLOCK_HALF;
            if (slot_visible(i) && !m_mask[i] && distance(x, song_x[i]) <= half &&
                distance(y, song_y[i]) <= `BLOCK_HALF && (best < 0 || rem < best_rem)) begin
                best     = i;
                best_rem = rem;
            end
        end
        if (best < 0) begin
            return 12'h000;
        end else if (song_kind[best] != 0) begin
            return 12'h888;
        end else if (song_color[best] != 0) begin
            return 12'h00f;
        end
        return 12'hf00;
    endfunction

    task automatic model_start();
        m_state  = saber_pkg::state_playing;
        m_time   = 0;
        m_mask   = '0;
        m_score  = 0;
        m_combo  = 0;
        m_health = `HEALTH_MAX;
    endtask

    task automatic model_tick();
        int  slice_slot;
        int  damage;
        slice_slot = -1;
        damage     = 0;
        if (m_state == saber_pkg::state_playing) begin
            m_time++;
            if (m_time >= `SONG_LEN) begin
                m_state = saber_pkg::state_over;
            end else begin
                for (int i = 0; i < `NUM_BLOCKS; i++) begin
                    if (slot_visible(i) && song_time[i] + `LEAD_TICKS - m_time == 1) begin
                        if (song_kind[i] != 0) begin
                            if (distance(head_x, song_x[i]) <= song_half[i]) damage += 2;
                        end else if (!m_mask[i]) begin
                            if (distance(saber_x, song_x[i]) <= `BLOCK_HALF &&
                                distance(saber_y, song_y[i]) <= `BLOCK_HALF) begin
                                if (slice_slot < 0) slice_slot = i;
                            end else begin
                                damage = damage | 1;
                            end
                        end
                    end
                end
                if (slice_slot >= 0) begin
                    m_combo = (m_combo < `COMBO_MAX) ? m_combo + 1 : m_combo;
                    m_score = m_score + m_combo;
                    m_mask[slice_slot] = 1'b1;
                end
                if (damage > 0) begin
                    m_combo  = 0;
                    m_health = (m_health > damage) ? m_health - damage : 0;
                end
                if (m_health == 0) m_state = saber_pkg::state_over;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    task automatic set_player(input int sx, input int sy, input int hx);
        @(negedge clk_in);
        saber_x = 12'(sx);
        saber_y = 12'(sy);
        head_x  = 12'(hx);
    endtask

    task automatic start_game();
        @(negedge clk_in);
        start = 1'b1;
        @(negedge clk_in);
        start = 1'b0;
        model_start();
        check_state("state_out after start", state_out, m_state);
    endtask

    // one strobe, then idle so strobes stay 8 cycles apart
    task automatic tick_frame();
        @(negedge clk_in);
        frame_tick = 1'b1;
        @(negedge clk_in);
        frame_tick = 1'b0;
        repeat (6) @(negedge clk_in);
        model_tick();
    endtask

    task automatic tick_until(input int t);
        while (m_time < t && m_state == saber_pkg::state_playing) begin
            tick_frame();
        end
    endtask

    task automatic add_pixel(input int x, input int y);
        px_q.push_back(x);
        py_q.push_back(y);
    endtask

    // one pixel per cycle, result two cycles behind
    task automatic run_pixels();
        int          n;
        logic [11:0] exp_c;
        n = px_q.size();
        for (int i = 0; i < n + 2; i++) begin
            @(negedge clk_in);
            if (i >= 2) begin
                exp_c = expected_rgb(px_q[i-2], py_q[i-2]);
                check_rgb($sformatf("rgb at %0d,%0d", px_q[i-2], py_q[i-2]),
                          r_out, g_out, b_out, exp_c[11:8], exp_c[7:4], exp_c[3:0]);
            end
            if (i < n) begin
                x_in = 11'(px_q[i]);
                y_in = 10'(py_q[i]);
            end
        end
        px_q.delete();
        py_q.delete();
    endtask

    task automatic check_counters();
        check_count("score_out", score_out, 8'(m_score));
        check_count("health_out", {4'd0, health_out}, 8'(m_health));
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic reset_and_start();
        check_state("state_out after reset", state_out, m_state);
        check_counters();
        check_rgb("rgb after reset", r_out, g_out, b_out, 4'h0, 4'h0, 4'h0);
        start_game();
    endtask

    task automatic pixel_pipeline();
        set_player(600, 450, 0);
        tick_until(3);
        add_pixel(100, 100);
        add_pixel(600, 400);
        run_pixels();
        // back to back, two in flight
        add_pixel(100, 100);
        add_pixel(600, 400);
        add_pixel(90, 110);
        add_pixel(117, 100);
        add_pixel(116, 84);
        add_pixel(100, 100);
        run_pixels();
    endtask

    task automatic slice_and_combo();
        set_player(100, 100, 0);
        tick_until(5);
        check_counters();
        add_pixel(100, 100);
        run_pixels();
        set_player(300, 100, 0);
        tick_until(7);
        check_counters();
        add_pixel(300, 100);
        add_pixel(100, 100);
        run_pixels();
    endtask

    task automatic miss_and_obstacle();
        set_player(600, 450, 200);
        tick_until(9);
        check_counters();
        set_player(600, 450, 0);
        tick_until(13);
        check_counters();
    endtask

    task automatic song_end_and_restart();
        tick_until(`SONG_LEN);
        check_state("state_out at song end", state_out, m_state);
        add_pixel(100, 100);
        add_pixel(400, 300);
        add_pixel(0, 0);
        run_pixels();
        start_game();
        check_counters();
    endtask

    // random pixels around slot 1 and the obstacle
    task automatic depth_priority();
        set_player(100, 100, 0);
        tick_until(5);
        check_counters();
        set_player(600, 450, 0);
        for (int t = 6; t <= 7; t++) begin
            tick_until(t);
            for (int k = 0; k < 20; k++) begin
                rng = xorshift32(rng);
                px_q.push_back(150 + int'(rng % 181));
                rng = xorshift32(rng);
                py_q.push_back(80 + int'(rng % 151));
            end
            run_pixels();
        end
        check_counters();
    endtask

    // slot 1 was missed, so the slice of slot 3 starts a new combo
    task automatic combo_reset_after_miss();
        set_player(600, 450, 0);
        tick_until(12);
        set_player(400, 300, 0);
        tick_until(13);
        check_counters();
        set_player(600, 450, 0);
        tick_until(`SONG_LEN);
        check_state("state_out at second song end", state_out, m_state);
    endtask

    initial begin
        rst_n      = 1'b0;
        start      = 1'b0;
        frame_tick = 1'b0;
        x_in       = '0;
        y_in       = '0;
        saber_x    = '0;
        saber_y    = '0;
        head_x     = '0;
        errors     = 0;
        checks     = 0;
        rng        = 32'd10;
        m_state    = saber_pkg::state_idle;
        m_time     = 0;
        m_mask     = '0;
        m_score    = 0;
        m_combo    = 0;
        m_health   = `HEALTH_MAX;
        repeat (16) @(negedge clk_in);
        rst_n = 1'b1;
        repeat (2) @(negedge clk_in);

        reset_and_start();
        pixel_pipeline();
        slice_and_combo();
        miss_and_obstacle();
        song_end_and_restart();
        depth_priority();
        combo_reset_after_miss();

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
saber_pkg.sv
block_loader.sv
block_positions.sv
block_selector.sv
slice_detector.sv
game_state.sv
pixel_renderer.sv
game_logic_and_renderer.sv
saber_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= saber_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard *.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
